/* hdl/tlb_params.svh */
`ifndef TLB_PARAMS_SVH
`define TLB_PARAMS_SVH

// Address space
`define TLB_VA_WIDTH       32
`define TLB_PA_WIDTH       40
`define TLB_PAGE_BITS      12   // 4 kB pages

// Set-associative geometry
`define TLB_SETS           8
`define TLB_SET_BITS       3
`define TLB_NUM_OFFSET     4    // Rows per set in each bank
`define TLB_OFFSET_BITS    2
`define TLB_NUM_BANKS      4
`define TLB_BANK_BITS      2

// Entry fields
`define TLB_TAG_BITS       17   // VA page number above the set bits
`define TLB_PPN_BITS       28
`define TLB_ENTRY_VALID    31
`define TLB_ENTRY_WR       30
`define TLB_ENTRY_RD       29

// Config port, address is {set, row, bank}
`define TLB_CFG_ADDR_BITS  7
`define TLB_CFG_DATA_BITS  32

`endif

/* hdl/tlb_pkg.sv */
`default_nettype none

`include "tlb_params.svh"

package tlb_pkg;

   // Search sequencer
   typedef enum logic [1:0] {
      IDLE,
      SEARCH,
      WAIT     // All rows issued, verdict still in flight
   } seq_state_e;

   typedef enum logic [1:0] {
      V_HIT,
      V_MISS,
      V_PROT,
      V_MULTI
   } verdict_e;

   // Same bit order as the config address
   typedef struct packed {
      logic [`TLB_SET_BITS-1:0]    set;
      logic [`TLB_OFFSET_BITS-1:0] row;
      logic [`TLB_BANK_BITS-1:0]   bank;
   } entry_idx_t;

   typedef struct packed {
      logic                      valid;
      verdict_e                  kind;
      entry_idx_t                idx;       // Only meaningful for V_HIT
      logic [`TLB_PAGE_BITS-1:0] page_off;
   } verdict_t;

endpackage

`default_nettype wire

/* hdl/tlb_ifs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tlb_params.svh"

// Config writes, one strobe per table
interface tlb_cfg_if;
   logic                          va_we;
   logic                          pa_we;
   logic [`TLB_CFG_ADDR_BITS-1:0] addr;
   logic [`TLB_CFG_DATA_BITS-1:0] wdata;

   modport va (input va_we, addr, wdata);
   modport pa (input pa_we, addr, wdata);
endinterface

// One row per beat to all banks
interface tlb_search_if;
   logic                        valid;
   logic                        first;
   logic                        last;
   logic [`TLB_SET_BITS-1:0]    set;
   logic [`TLB_OFFSET_BITS-1:0] row;
   logic [`TLB_TAG_BITS-1:0]    tag;
   logic                        rw;    // 1 for write

   modport drv (output valid, first, last, set, row, tag, rw);
   modport rcv (input  valid, first, last, set, row, tag, rw);
endinterface

// Per-bank compare results of one row
interface tlb_beat_if;
   logic                        valid;
   logic                        first;
   logic                        last;
   logic [`TLB_NUM_BANKS-1:0]   hit;
   logic [`TLB_NUM_BANKS-1:0]   prot;
   logic [`TLB_SET_BITS-1:0]    set;
   logic [`TLB_OFFSET_BITS-1:0] row;

   modport drv (output valid, first, last, hit, prot, set, row);
   modport rcv (input  valid, first, last, hit, prot, set, row);
endinterface

`default_nettype wire

/* hdl/search_seq.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tlb_params.svh"

module search_seq (
   input  wire logic                     clk_i,
   input  wire logic                     rst_ni,
   input  wire logic                     l1_miss_i,
   input  wire logic [`TLB_VA_WIDTH-1:0] vaddr_i,
   input  wire logic                     rw_i,
   input  wire logic                     stop_i,     // Verdict issued
   output      logic                     busy_o,
   output      logic [`TLB_PAGE_BITS-1:0] page_off_o,
   tlb_search_if.drv                     srch
);

   typedef logic [`TLB_OFFSET_BITS-1:0] row_t;

   localparam row_t LAST_ROW = row_t'(`TLB_NUM_OFFSET - 1);

   tlb_pkg::seq_state_e      state_q, state_d;
   row_t                     row_q;
   logic                     busy_q;
   logic                     accept;
   logic                     last_row;
   logic [`TLB_VA_WIDTH-1:0] vaddr_q;
   logic                     rw_q;

   // New lookups only once the previous result is out
   assign accept   = l1_miss_i && !busy_q && (state_q == tlb_pkg::IDLE);
   assign last_row = (row_q == LAST_ROW);

   //////////////////////////////////////////////////
   // FSM
   //////////////////////////////////////////////////
   always_comb begin
      state_d = state_q;
      case (state_q)
         tlb_pkg::IDLE: begin
            if (accept) state_d = tlb_pkg::SEARCH;
         end
         tlb_pkg::SEARCH: begin
            if (stop_i) begin
               state_d = tlb_pkg::IDLE;   // Early verdict wins over last row
            end else if (last_row) begin
               state_d = tlb_pkg::WAIT;
            end
         end
         tlb_pkg::WAIT: begin
            if (stop_i) state_d = tlb_pkg::IDLE;
         end
         default: state_d = tlb_pkg::IDLE;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
         state_q <= tlb_pkg::IDLE;
         row_q   <= '0;
         busy_q  <= 1'b0;
      end else begin
         state_q <= state_d;
         if (accept) begin
            row_q  <= '0;
            busy_q <= 1'b1;
         end else begin
            if (state_q == tlb_pkg::SEARCH) row_q <= row_q + 1'b1;
            // IDLE one cycle after stop, result pulse already out
            if (state_q == tlb_pkg::IDLE) busy_q <= 1'b0;
         end
      end
   end

   // Request payload
   always_ff @(posedge clk_i) begin
      if (accept) begin
         vaddr_q <= vaddr_i;
         rw_q    <= rw_i;
      end
   end

   //////////////////////////////////////////////////
   // Beat outputs
   //////////////////////////////////////////////////
   assign srch.valid = (state_q == tlb_pkg::SEARCH);
   assign srch.first = (row_q == '0);
   assign srch.last  = last_row;
   assign srch.row   = row_q;
   assign srch.set   = vaddr_q[`TLB_PAGE_BITS +: `TLB_SET_BITS];
   assign srch.tag   = vaddr_q[`TLB_VA_WIDTH-1 : `TLB_PAGE_BITS + `TLB_SET_BITS];
   assign srch.rw    = rw_q;

   assign busy_o     = busy_q;
   assign page_off_o = vaddr_q[`TLB_PAGE_BITS-1:0];

endmodule

`default_nettype wire

/* hdl/entry_banks.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tlb_params.svh"

module entry_banks (
   input  wire logic  clk_i,
   input  wire logic  rst_ni,
   tlb_cfg_if.va      cfg,
   tlb_search_if.rcv  srch,
   tlb_beat_if.drv    beat
);

   localparam int BANK_WORDS = `TLB_SETS * `TLB_NUM_OFFSET;
   localparam int WORD_BITS  = `TLB_SET_BITS + `TLB_OFFSET_BITS;

   typedef logic [`TLB_BANK_BITS-1:0]     bank_t;
   typedef logic [`TLB_CFG_DATA_BITS-1:0] entry_t;

   logic [WORD_BITS-1:0] cfg_word;
   entry_t               rd_q [`TLB_NUM_BANKS];

   // Beat tags after the RAM read
   logic                        s1_valid;
   logic                        s1_first;
   logic                        s1_last;
   logic [`TLB_SET_BITS-1:0]    s1_set;
   logic [`TLB_OFFSET_BITS-1:0] s1_row;
   logic [`TLB_TAG_BITS-1:0]    s1_tag;
   logic                        s1_rw;

   logic [`TLB_NUM_BANKS-1:0]   hit_d;
   logic [`TLB_NUM_BANKS-1:0]   prot_d;

   assign cfg_word = cfg.addr[`TLB_CFG_ADDR_BITS-1:`TLB_BANK_BITS];

   //////////////////////////////////////////////////
   // VA entry RAMs, bank picked by low addr bits
   //////////////////////////////////////////////////
   for (genvar g = 0; g < `TLB_NUM_BANKS; g++) begin : g_bank
      entry_t mem [BANK_WORDS];
      entry_t ent;

      always_ff @(posedge clk_i) begin
         if (cfg.va_we && (cfg.addr[`TLB_BANK_BITS-1:0] == bank_t'(g))) begin
            mem[cfg_word] <= cfg.wdata;
         end
         rd_q[g] <= mem[{srch.set, srch.row}];
      end

      assign ent      = rd_q[g];
      assign hit_d[g] = ent[`TLB_ENTRY_VALID] && (ent[`TLB_TAG_BITS-1:0] == s1_tag);
      // Permission bit for the requested access
      assign prot_d[g] = hit_d[g] && (s1_rw ? !ent[`TLB_ENTRY_WR] : !ent[`TLB_ENTRY_RD]);
   end

   //////////////////////////////////////////////////
   // Tag pipeline and compare register
   //////////////////////////////////////////////////
   always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
         s1_valid   <= 1'b0;
         beat.valid <= 1'b0;
      end else begin
         s1_valid   <= srch.valid;
         beat.valid <= s1_valid;
      end
   end

   always_ff @(posedge clk_i) begin
      s1_first <= srch.first;
      s1_last  <= srch.last;
      s1_set   <= srch.set;
      s1_row   <= srch.row;
      s1_tag   <= srch.tag;
      s1_rw    <= srch.rw;

      beat.first <= s1_first;
      beat.last  <= s1_last;
      beat.set   <= s1_set;
      beat.row   <= s1_row;
      beat.hit   <= hit_d;
      beat.prot  <= prot_d;
   end

endmodule

`default_nettype wire

/* hdl/hit_resolve.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tlb_params.svh"

module hit_resolve (
   input  wire logic                      clk_i,
   input  wire logic                      rst_ni,
   tlb_beat_if.rcv                        beat,
   input  wire logic [`TLB_PAGE_BITS-1:0] page_off_i,
   output      tlb_pkg::verdict_t         verdict_o
);

   typedef logic [`TLB_BANK_BITS-1:0] bank_t;

   logic                 done_q;    // Verdict already given for this search
   logic                 take;
   logic                 multi;
   logic                 any_hit;
   bank_t                hit_bank;
   logic                 vld_d;
   tlb_pkg::verdict_e    kind_d;

   logic                      vld_q;
   tlb_pkg::verdict_e         kind_q;
   tlb_pkg::entry_idx_t       idx_q;
   logic [`TLB_PAGE_BITS-1:0] off_q;

   // Leftover rows of a stopped search are dropped here
   assign take    = beat.valid && (beat.first || !done_q);
   assign multi   = (beat.hit & (beat.hit - 1'b1)) != '0;   // Two or more bits set
   assign any_hit = |beat.hit;

   // Lowest bank wins
   always_comb begin
      hit_bank = '0;
      for (int b = `TLB_NUM_BANKS - 1; b >= 0; b--) begin
         if (beat.hit[b]) hit_bank = bank_t'(b);
      end
   end

   always_comb begin
      vld_d  = 1'b1;
      kind_d = tlb_pkg::V_MISS;
      if (multi) begin
         kind_d = tlb_pkg::V_MULTI;
      end else if (|beat.prot) begin
         kind_d = tlb_pkg::V_PROT;
      end else if (any_hit) begin
         kind_d = tlb_pkg::V_HIT;
      end else if (!beat.last) begin
         vld_d = 1'b0;   // Nothing yet, keep searching
      end
      vld_d = vld_d && take;
   end

   always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
         vld_q  <= 1'b0;
         done_q <= 1'b0;
      end else begin
         vld_q <= vld_d;
         if (vld_d) begin
            done_q <= 1'b1;
         end else if (beat.valid && beat.first) begin
            done_q <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      kind_q <= kind_d;
      idx_q  <= '{set: beat.set, row: beat.row, bank: hit_bank};
      off_q  <= page_off_i;
   end

   assign verdict_o = '{valid: vld_q, kind: kind_q, idx: idx_q, page_off: off_q};

endmodule

`default_nettype wire

/* hdl/pa_table.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tlb_params.svh"

module pa_table (
   input  wire logic                     clk_i,
   input  wire logic                     rst_ni,
   tlb_cfg_if.pa                         cfg,
   input  wire tlb_pkg::verdict_t        verdict_i,
   output      logic                     hit_o,
   output      logic                     miss_o,
   output      logic                     prot_o,
   output      logic                     multi_hit_o,
   output      logic [`TLB_PA_WIDTH-1:0] out_addr_o
);

   localparam int PA_DEPTH = `TLB_SETS * `TLB_NUM_OFFSET * `TLB_NUM_BANKS;

   typedef logic [`TLB_PPN_BITS-1:0] ppn_t;

   ppn_t                      mem [PA_DEPTH];
   ppn_t                      ppn_q;
   logic [`TLB_PAGE_BITS-1:0] off_q;
   logic                      fire;

   assign fire = verdict_i.valid;

   //////////////////////////////////////////////////
   // PA RAM
   //////////////////////////////////////////////////
   always_ff @(posedge clk_i) begin
      if (cfg.pa_we) begin
         mem[cfg.addr] <= cfg.wdata[`TLB_PPN_BITS-1:0];
      end
   end

   // Read only on a verdict so out_addr_o holds between lookups
   always_ff @(posedge clk_i) begin
      if (fire) begin
         ppn_q <= mem[verdict_i.idx];
         off_q <= verdict_i.page_off;
      end
   end

   //////////////////////////////////////////////////
   // Result pulses, aligned with the RAM read
   //////////////////////////////////////////////////
   always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
         hit_o       <= 1'b0;
         miss_o      <= 1'b0;
         prot_o      <= 1'b0;
         multi_hit_o <= 1'b0;
      end else begin
         hit_o       <= fire && (verdict_i.kind == tlb_pkg::V_HIT);
         miss_o      <= fire && (verdict_i.kind == tlb_pkg::V_MISS);
         prot_o      <= fire && (verdict_i.kind == tlb_pkg::V_PROT);
         multi_hit_o <= fire && (verdict_i.kind == tlb_pkg::V_MULTI);
      end
   end

   assign out_addr_o = {ppn_q, off_q};   // Page offset passes through

endmodule

`default_nettype wire

/* hdl/tlb_l2.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tlb_params.svh"

module tlb_l2 (
   input  wire logic                          clk_i,
   input  wire logic                          rst_ni,
   // Lookup
   input  wire logic                          l1_miss_i,
   input  wire logic [`TLB_VA_WIDTH-1:0]      vaddr_i,
   input  wire logic                          rw_i,        // 1 for write
   // Config, only while idle
   input  wire logic                          va_we_i,
   input  wire logic                          pa_we_i,
   input  wire logic [`TLB_CFG_ADDR_BITS-1:0] cfg_addr_i,
   input  wire logic [`TLB_CFG_DATA_BITS-1:0] cfg_wdata_i,
   // Result
   output      logic                          busy_o,
   output      logic                          hit_o,
   output      logic                          miss_o,
   output      logic                          prot_o,
   output      logic                          multi_hit_o,
   output      logic [`TLB_PA_WIDTH-1:0]      out_addr_o
);

   tlb_cfg_if    cfg_if ();
   tlb_search_if srch_if ();
   tlb_beat_if   beat_if ();

   logic                      stop;
   logic [`TLB_PAGE_BITS-1:0] page_off;
   tlb_pkg::verdict_t         verdict;

   assign cfg_if.va_we = va_we_i;
   assign cfg_if.pa_we = pa_we_i;
   assign cfg_if.addr  = cfg_addr_i;
   assign cfg_if.wdata = cfg_wdata_i;

   assign stop = verdict.valid;   // Frees the sequencer

   search_seq u_seq (
      .clk_i      (clk_i),
      .rst_ni     (rst_ni),
      .l1_miss_i  (l1_miss_i),
      .vaddr_i    (vaddr_i),
      .rw_i       (rw_i),
      .stop_i     (stop),
      .busy_o     (busy_o),
      .page_off_o (page_off),
      .srch       (srch_if)
   );

   entry_banks u_banks (
      .clk_i  (clk_i),
      .rst_ni (rst_ni),
      .cfg    (cfg_if),
      .srch   (srch_if),
      .beat   (beat_if)
   );

   hit_resolve u_resolve (
      .clk_i      (clk_i),
      .rst_ni     (rst_ni),
      .beat       (beat_if),
      .page_off_i (page_off),
      .verdict_o  (verdict)
   );

   pa_table u_pa (
      .clk_i       (clk_i),
      .rst_ni      (rst_ni),
      .cfg         (cfg_if),
      .verdict_i   (verdict),
      .hit_o       (hit_o),
      .miss_o      (miss_o),
      .prot_o      (prot_o),
      .multi_hit_o (multi_hit_o),
      .out_addr_o  (out_addr_o)
   );

endmodule

`default_nettype wire

/* test/tlb_model.svh */
`ifndef TLB_MODEL_SVH
`define TLB_MODEL_SVH

// Expected verdict kinds
localparam int K_HIT   = 0;
localparam int K_MISS  = 1;
localparam int K_PROT  = 2;
localparam int K_MULTI = 3;

localparam int N_ENTRIES = `TLB_SETS * `TLB_NUM_OFFSET * `TLB_NUM_BANKS;

// Shadow copies of both tables, indexed {set, row, bank}
logic [`TLB_CFG_DATA_BITS-1:0] va_shadow [N_ENTRIES];
logic [`TLB_PPN_BITS-1:0]      pa_shadow [N_ENTRIES];
logic [31:0]                   lcg_state = 32'd30294;

function automatic logic [15:0] lcg_next();
   lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
   return lcg_state[31:16];   // Low bits of an LCG repeat too soon
endfunction

function automatic logic [31:0] rand_word();
   logic [15:0] hi;
   hi = lcg_next();
   return {hi, lcg_next()};
endfunction

// Rows scanned in order, first row with a verdict ends the search
function automatic void ref_lookup(input logic [`TLB_VA_WIDTH-1:0] va, input logic rw,
                                   output int kind, output logic [`TLB_PA_WIDTH-1:0] pa,
                                   output int row);
   logic [`TLB_SET_BITS-1:0]      set;
   logic [`TLB_TAG_BITS-1:0]      tag;
   logic [`TLB_CFG_DATA_BITS-1:0] ent;
   logic                          denied;
   int                            hits;
   int                            base;
   int                            first;
   set  = va[`TLB_PAGE_BITS +: `TLB_SET_BITS];
   tag  = va[`TLB_VA_WIDTH-1 -: `TLB_TAG_BITS];
   kind = K_MISS;
   pa   = '0;
   for (row = 0; row < `TLB_NUM_OFFSET; row++) begin
      hits   = 0;
      denied = 1'b0;
      first  = 0;
      for (int b = `TLB_NUM_BANKS - 1; b >= 0; b--) begin
         base = (int'(set) * `TLB_NUM_OFFSET + row) * `TLB_NUM_BANKS + b;
         ent  = va_shadow[base];
         if (ent[`TLB_ENTRY_VALID] && ent[`TLB_TAG_BITS-1:0] == tag) begin
            hits++;
            first = base;   // Descending scan leaves the lowest bank
            if (rw ? !ent[`TLB_ENTRY_WR] : !ent[`TLB_ENTRY_RD]) denied = 1'b1;
         end
      end
      if (hits > 1) begin
         kind = K_MULTI;
         return;
      end else if (denied) begin
         kind = K_PROT;
         return;
      end else if (hits == 1) begin
         kind = K_HIT;
         pa   = {pa_shadow[first], va[`TLB_PAGE_BITS-1:0]};
         return;
      end
   end
   row = `TLB_NUM_OFFSET - 1;   // Miss ends on the last row
endfunction

`endif

/* test/tb_tlb_l2.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tlb_params.svh"

module tb_tlb_l2;

   `include "tlb_model.svh"

   localparam int N_RAND_FILLS    = 64;
   localparam int N_RAND_LOOKUPS  = 300;
   localparam int N_DIRECTED      = 16;                  // Bound on directed writes and lookups
   localparam int ROW0_LATENCY    = 5;                   // Accept edge to sampled pulse, row 0
   localparam int MAX_RESULT_WAIT = `TLB_NUM_OFFSET + 8;
   localparam int MAX_CYCLES      = (N_RAND_LOOKUPS + N_DIRECTED) * 20
                                    + (2 * N_ENTRIES + N_RAND_FILLS + N_DIRECTED) * 3 + 100;

   logic                          clk_i = 1'b0;
   logic                          rst_ni;
   logic                          l1_miss_i;
   logic [`TLB_VA_WIDTH-1:0]      vaddr_i;
   logic                          rw_i;
   logic                          va_we_i;
   logic                          pa_we_i;
   logic [`TLB_CFG_ADDR_BITS-1:0] cfg_addr_i;
   logic [`TLB_CFG_DATA_BITS-1:0] cfg_wdata_i;
   logic                          busy_o;
   logic                          hit_o;
   logic                          miss_o;
   logic                          prot_o;
   logic                          multi_hit_o;
   logic [`TLB_PA_WIDTH-1:0]      out_addr_o;

   int                       cycle       = 0;
   int                       err_value   = 0;
   int                       err_missing = 0;
   int                       req_cnt     = 0;
   int                       done_cnt    = 0;
   int                       exp_kind_q [$];
   int                       exp_row_q  [$];
   logic [`TLB_PA_WIDTH-1:0] exp_addr_q [$];

   tlb_l2 dut0 (.*);

   always #2 clk_i = ~clk_i;

   always @(posedge clk_i) cycle <= cycle + 1;

   //////////////////////////////////////////////////
   // Field packing helpers
   //////////////////////////////////////////////////
   function automatic logic [`TLB_VA_WIDTH-1:0] make_va(input logic [`TLB_TAG_BITS-1:0] tag,
         input logic [`TLB_SET_BITS-1:0] set, input logic [`TLB_PAGE_BITS-1:0] off);
      return {tag, set, off};
   endfunction

   function automatic logic [`TLB_CFG_DATA_BITS-1:0] make_entry(input logic v, input logic wr,
         input logic rd, input logic [`TLB_TAG_BITS-1:0] tag);
      logic [`TLB_CFG_DATA_BITS-1:0] ent;
      ent                      = '0;
      ent[`TLB_ENTRY_VALID]    = v;
      ent[`TLB_ENTRY_WR]       = wr;
      ent[`TLB_ENTRY_RD]       = rd;
      ent[`TLB_TAG_BITS-1:0]   = tag;
      return ent;
   endfunction

   function automatic logic [`TLB_CFG_ADDR_BITS-1:0] entry_idx(input logic [2:0] set,
         input logic [1:0] row, input logic [1:0] bank);
      return {set, row, bank};
   endfunction

   // Small tag pool so random fills collide
   function automatic logic [`TLB_TAG_BITS-1:0] pool_tag(input logic [2:0] k);
      return {k, 14'h2A5A};
   endfunction

   //////////////////////////////////////////////////
   // Stimulus tasks
   //////////////////////////////////////////////////
   task automatic write_entry(input logic [`TLB_CFG_ADDR_BITS-1:0] addr,
         input logic [`TLB_CFG_DATA_BITS-1:0] va_word, input logic [`TLB_PPN_BITS-1:0] ppn);
      @(posedge clk_i);
      va_we_i     <= 1'b1;
      cfg_addr_i  <= addr;
      cfg_wdata_i <= va_word;
      @(posedge clk_i);
      va_we_i     <= 1'b0;
      pa_we_i     <= 1'b1;
      cfg_wdata_i <= {{(`TLB_CFG_DATA_BITS - `TLB_PPN_BITS){1'b0}}, ppn};
      @(posedge clk_i);
      pa_we_i <= 1'b0;
      va_shadow[addr] = va_word;
      pa_shadow[addr] = ppn;
   endtask

   task automatic clear_tables();
      for (int i = 0; i < N_ENTRIES; i++) write_entry(i[`TLB_CFG_ADDR_BITS-1:0], '0, '0);
   endtask

   task automatic lookup(input logic [`TLB_VA_WIDTH-1:0] va, input logic rw);
      int                       kind;
      int                       row;
      logic [`TLB_PA_WIDTH-1:0] pa;
      ref_lookup(va, rw, kind, pa, row);
      @(posedge clk_i);
      l1_miss_i <= 1'b1;
      vaddr_i   <= va;
      rw_i      <= rw;
      @(posedge clk_i);   // Accepting edge
      l1_miss_i <= 1'b0;
      exp_kind_q.push_back(kind);
      exp_row_q.push_back(row);
      exp_addr_q.push_back(pa);
      req_cnt++;
      wait (done_cnt == req_cnt);
   endtask

   //////////////////////////////////////////////////
   // Comparing process
   //////////////////////////////////////////////////
   initial begin : compare_results
      int                       n;
      int                       npulse;
      int                       kind;
      int                       want_kind;
      int                       want_row;
      logic [`TLB_PA_WIDTH-1:0] want_addr;
      forever begin
         wait (req_cnt != done_cnt);
         want_kind = exp_kind_q.pop_front();
         want_row  = exp_row_q.pop_front();
         want_addr = exp_addr_q.pop_front();
         n         = 0;
         npulse    = 0;
         while (npulse == 0 && n < MAX_RESULT_WAIT) begin
            @(negedge clk_i);
            n++;
            npulse = int'(hit_o) + int'(miss_o) + int'(prot_o) + int'(multi_hit_o);
         end
         if (npulse == 0) begin
            $display("No result pulse within %0d cycles for lookup %0d", n, done_cnt);
            err_missing++;
         end else begin
            kind = hit_o ? K_HIT : (miss_o ? K_MISS : (prot_o ? K_PROT : K_MULTI));
            if (npulse > 1) begin
               $display("ERR @%0t: %0d result pulses high at once", $time, npulse);
               err_value++;
            end else if (kind != want_kind) begin
               $display("ERR @%0t: verdict %0d, expected %0d", $time, kind, want_kind);
               err_value++;
            end else if (kind == K_HIT && out_addr_o != want_addr) begin
               $display("ERR @%0t: out_addr_o %h, expected %h", $time, out_addr_o, want_addr);
               err_value++;
            end
            if (n != want_row + ROW0_LATENCY) begin
               $display("ERR @%0t: result after %0d cycles, expected %0d", $time, n,
                        want_row + ROW0_LATENCY);
               err_value++;
            end
            @(negedge clk_i);
            // Single-cycle pulse, TLB free again
            if (busy_o || hit_o || miss_o || prot_o || multi_hit_o) begin
               $display("ERR @%0t: busy_o or a result pulse still high after result", $time);
               err_value++;
            end
         end
         done_cnt++;
      end
   end

   initial begin : watchdog
      wait (cycle >= MAX_CYCLES);
      $display("Run stopped at the limit of %0d cycles before all lookups finished", MAX_CYCLES);
      $display("SOME TESTS FAILED");
      $finish;
   end

   //////////////////////////////////////////////////
   // Test sequence
   //////////////////////////////////////////////////
   initial begin : stimulus
      logic [31:0]              r;
      logic [31:0]              p;
      logic [`TLB_TAG_BITS-1:0] tag;
      rst_ni      = 1'b0;
      l1_miss_i   = 1'b0;
      vaddr_i     = '0;
      rw_i        = 1'b0;
      va_we_i     = 1'b0;
      pa_we_i     = 1'b0;
      cfg_addr_i  = '0;
      cfg_wdata_i = '0;
      repeat (8) @(posedge clk_i);
      rst_ni <= 1'b1;
      @(negedge clk_i);
      if (busy_o || hit_o || miss_o || prot_o || multi_hit_o) begin
         $display("ERR @%0t: outputs not idle after reset", $time);
         err_value++;
      end
      clear_tables();
      lookup(make_va(17'h1A2B3, 3'd1, 12'h123), 1'b0);   // Empty tables, full miss

      // Hits across banks and rows
      write_entry(entry_idx(3'd1, 2'd0, 2'd2), make_entry(1, 1, 1, 17'h1A2B3), 28'hABCDE01);
      write_entry(entry_idx(3'd5, 2'd2, 2'd0), make_entry(1, 1, 1, 17'h00042), 28'h1234567);
      write_entry(entry_idx(3'd7, 2'd3, 2'd3), make_entry(1, 1, 1, 17'h1FFFF), 28'hFFFFFFF);
      lookup(make_va(17'h1A2B3, 3'd1, 12'h456), 1'b0);
      lookup(make_va(17'h00042, 3'd5, 12'hFFF), 1'b1);
      lookup(make_va(17'h1FFFF, 3'd7, 12'h001), 1'b0);

      // WR cleared, write denied and read allowed
      write_entry(entry_idx(3'd3, 2'd1, 2'd1), make_entry(1, 0, 1, 17'h0BEEF), 28'h0C0FFEE);
      lookup(make_va(17'h0BEEF, 3'd3, 12'h0AB), 1'b1);
      lookup(make_va(17'h0BEEF, 3'd3, 12'h0AB), 1'b0);

      // Same tag twice in one row, then in two rows
      write_entry(entry_idx(3'd6, 2'd0, 2'd0), make_entry(1, 1, 1, 17'h00777), 28'h0000111);
      write_entry(entry_idx(3'd6, 2'd0, 2'd3), make_entry(1, 1, 1, 17'h00777), 28'h0000222);
      write_entry(entry_idx(3'd2, 2'd2, 2'd1), make_entry(1, 1, 1, 17'h05555), 28'h0000333);
      write_entry(entry_idx(3'd2, 2'd3, 2'd2), make_entry(1, 1, 1, 17'h05555), 28'h0000444);
      lookup(make_va(17'h00777, 3'd6, 12'h010), 1'b0);
      lookup(make_va(17'h05555, 3'd2, 12'h020), 1'b1);

      // Random fills and lookups
      clear_tables();
      for (int i = 0; i < N_RAND_FILLS; i++) begin
         r = rand_word();
         p = rand_word();
         tag = pool_tag(r[10:8]);
         write_entry(r[6:0], make_entry(r[13:11] != 3'd0, r[15:14] != 2'd0, r[18:16] != 3'd0,
                     tag), p[`TLB_PPN_BITS-1:0]);
      end
      for (int i = 0; i < N_RAND_LOOKUPS; i++) begin
         r = rand_word();
         p = rand_word();
         tag = (r[1:0] != 2'd0) ? pool_tag(r[4:2]) : p[`TLB_TAG_BITS-1:0];
         lookup(make_va(tag, r[7:5], r[19:8]), r[20]);
      end

      repeat (2) @(posedge clk_i);
      $display("Errors: %0d wrong values, %0d missing results, %0d lookups checked",
               err_value, err_missing, done_cnt);
      if (err_value == 0 && err_missing == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* all.f */
+incdir+hdl
+incdir+test
hdl/tlb_pkg.sv
hdl/tlb_ifs.sv
hdl/search_seq.sv
hdl/entry_banks.sv
hdl/hit_resolve.sv
hdl/pa_table.sv
hdl/tlb_l2.sv
test/tb_tlb_l2.sv

/* run.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f all.f --top-module tb_tlb_l2 -o tb_tlb_l2_sim

./obj_dir/tb_tlb_l2_sim | tee sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
   echo "Simulation passed"
else
   echo "Simulation failed"
   exit 1
fi
